// ==== cacheaq_config.svh ====
`ifndef AQ_CFG_SVH
`define AQ_CFG_SVH

// physical line address, one line per request
`define AQ_ADDR_W 15

// data line and its byte mask
`define AQ_DATA_W 128
`define AQ_MASK_W 16

// auxiliary word, decoded per source
`define AQ_AUX_W 24

// entries in each queue
`define AQ_DEPTH 8

`endif

// ==== cacheaq_pkg.sv ====
`include "cacheaq_config.svh"

package cacheaq_pkg;

    // view used for rd and sw requests
    typedef struct packed {
        logic [7:0] qslot;
        logic [6:0] ptcid;
        logic [2:0] onesize;
        logic       needp1;
        logic       pcd;
        logic       odd_is_greater;
        logic [2:0] pad;
    } aq_rd_aux_t;

    // view used for wb and bus requests
    typedef struct packed {
        logic [`AQ_MASK_W-1:0] byte_mask; // one bit per data byte
        logic [2:0]            onesize;
        logic                  needp1;
        logic                  pcd;
        logic                  odd_is_greater;
        logic [1:0]            pad;
    } aq_wb_aux_t;

    // same 24 bits, the source tells which view applies
    typedef union packed {
        aq_rd_aux_t rd;
        aq_wb_aux_t wb;
    } aq_aux_u;

endpackage

// ==== aq_fifo.sv ====
`timescale 1ns/100ps

module aq_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 8
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             clr_i,
    input  logic             push_i,
    input  logic             pop_i,
    input  logic [WIDTH-1:0] din_i,
    output logic [WIDTH-1:0] dout_o,
    output logic             empty_o,
    output logic             full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1; // wrap for any depth
    endfunction

    assign do_push = push_i && !full_o; // drop when full
    assign do_pop  = pop_i && !empty_o;
    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(DEPTH));
    assign dout_o  = mem[rd_ptr]; // head shows through

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= din_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || clr_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

endmodule

// ==== rdsw_queues.sv ====
`timescale 1ns/100ps
`include "cacheaq_config.svh"

module rdsw_queues (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  clr_i,
    input  logic                  rd_write_i,
    input  logic [`AQ_ADDR_W-1:0] rd_addr_i,
    input  cacheaq_pkg::aq_aux_u  rd_aux_i,
    input  logic                  sw_write_i,
    input  logic [`AQ_ADDR_W-1:0] sw_addr_i,
    input  cacheaq_pkg::aq_aux_u  sw_aux_i,
    input  logic                  pop_i,
    output logic                  valid_o,
    output logic                  is_sw_o,
    output logic [`AQ_ADDR_W-1:0] addr_o,
    output cacheaq_pkg::aq_aux_u  aux_o,
    output logic                  rd_full_o,
    output logic                  sw_full_o
);

    localparam int ENT_W = `AQ_ADDR_W + `AQ_AUX_W;

    logic [ENT_W-1:0] rd_head;
    logic [ENT_W-1:0] sw_head;
    logic             rd_empty;
    logic             sw_empty;
    logic             rd_pop;
    logic             sw_pop;

    aq_fifo #(.WIDTH(ENT_W), .DEPTH(`AQ_DEPTH)) u_rd_fifo (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .clr_i   (clr_i),
        .push_i  (rd_write_i),
        .pop_i   (rd_pop),
        .din_i   ({rd_addr_i, rd_aux_i}),
        .dout_o  (rd_head),
        .empty_o (rd_empty),
        .full_o  (rd_full_o)
    );

    aq_fifo #(.WIDTH(ENT_W), .DEPTH(`AQ_DEPTH)) u_sw_fifo (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .clr_i   (clr_i),
        .push_i  (sw_write_i),
        .pop_i   (sw_pop),
        .din_i   ({sw_addr_i, sw_aux_i}),
        .dout_o  (sw_head),
        .empty_o (sw_empty),
        .full_o  (sw_full_o)
    );

    assign is_sw_o = !sw_empty; // store-write goes ahead of read
    assign valid_o = !sw_empty || !rd_empty;
    assign {addr_o, aux_o} = is_sw_o ? sw_head : rd_head;

    // pop only the queue whose head is on offer
    assign sw_pop = pop_i && !sw_empty;
    assign rd_pop = pop_i && sw_empty;

endmodule

// ==== wb_queue.sv ====
`timescale 1ns/100ps
`include "cacheaq_config.svh"

module wb_queue (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  clr_i,
    input  logic                  write_i,
    input  logic [`AQ_ADDR_W-1:0] addr_i,
    input  logic [`AQ_DATA_W-1:0] data_i,
    input  cacheaq_pkg::aq_aux_u  aux_i,
    input  logic                  pop_i,
    output logic                  valid_o,
    output logic [`AQ_ADDR_W-1:0] addr_o,
    output logic [`AQ_DATA_W-1:0] data_o,
    output cacheaq_pkg::aq_aux_u  aux_o,
    output logic                  full_o
);

    localparam int DEPTH = `AQ_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [`AQ_ADDR_W-1:0] addr_mem [DEPTH];
    logic [`AQ_DATA_W-1:0] data_mem [DEPTH];
    cacheaq_pkg::aq_aux_u  aux_mem  [DEPTH];

    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [PTR_W-1:0]      tail_ptr;
    logic [CNT_W-1:0]      count;
    logic                  empty;
    logic                  do_pop;
    logic                  merge;
    logic                  append;
    logic [`AQ_DATA_W-1:0] merged_data;
    cacheaq_pkg::aq_aux_u  merged_aux;

    assign empty    = (count == '0);
    assign full_o   = (count == CNT_W'(DEPTH));
    assign valid_o  = !empty;
    assign tail_ptr = (wr_ptr == '0) ? PTR_W'(DEPTH - 1) : wr_ptr - 1'b1; // newest entry
    assign do_pop   = pop_i && !empty;

    // a single entry being popped is both head and tail, so no merge then
    assign merge  = write_i && !empty && (addr_mem[tail_ptr] == addr_i)
                    && !(do_pop && (count == CNT_W'(1)));
    assign append = write_i && !merge && !full_o; // merge still works when full

    assign addr_o = addr_mem[rd_ptr];
    assign data_o = data_mem[rd_ptr];
    assign aux_o  = aux_mem[rd_ptr];

    always_comb begin
        merged_data = data_mem[tail_ptr];
        for (int b = 0; b < `AQ_MASK_W; b++) begin
            if (aux_i.wb.byte_mask[b]) begin
                merged_data[b*8 +: 8] = data_i[b*8 +: 8]; // new byte wins
            end
        end
        merged_aux = aux_i; // other fields follow the new write
        merged_aux.wb.byte_mask = aux_mem[tail_ptr].wb.byte_mask | aux_i.wb.byte_mask;
    end

    always_ff @(posedge clk_i) begin
        if (merge) begin
            data_mem[tail_ptr] <= merged_data;
            aux_mem[tail_ptr]  <= merged_aux;
        end else if (append) begin
            addr_mem[wr_ptr] <= addr_i;
            data_mem[wr_ptr] <= data_i;
            aux_mem[wr_ptr]  <= aux_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || clr_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (append) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(append) - CNT_W'(do_pop);
        end
    end

endmodule

// ==== aq_arbiter.sv ====
`timescale 1ns/100ps
`include "cacheaq_config.svh"

module aq_arbiter (
    input  logic                  bus_ready_i,
    input  logic [`AQ_ADDR_W-1:0] bus_addr_i,
    input  logic [`AQ_DATA_W-1:0] bus_data_i,
    input  logic                  wb_valid_i,
    input  logic [`AQ_ADDR_W-1:0] wb_addr_i,
    input  logic [`AQ_DATA_W-1:0] wb_data_i,
    input  cacheaq_pkg::aq_aux_u  wb_aux_i,
    input  logic                  rdsw_valid_i,
    input  logic                  rdsw_is_sw_i,
    input  logic [`AQ_ADDR_W-1:0] rdsw_addr_i,
    input  cacheaq_pkg::aq_aux_u  rdsw_aux_i,
    input  logic                  read_i,
    output logic                  valid_o,
    output logic [`AQ_ADDR_W-1:0] addr_o,
    output logic [`AQ_DATA_W-1:0] data_o,
    output cacheaq_pkg::aq_aux_u  aux_o,
    output logic                  from_bus_o,
    output logic                  w_o,
    output logic                  sw_o,
    output logic                  r_o,
    output logic                  bus_ack_o,
    output logic                  wb_pop_o,
    output logic                  rdsw_pop_o,
    output logic                  aq_empty_o
);

    logic                 bus_sel;
    logic                 wb_sel;
    logic                 rdsw_sel;
    cacheaq_pkg::aq_aux_u bus_aux;

    // fixed priority bus, wb, rd/sw
    assign bus_sel  = bus_ready_i;
    assign wb_sel   = !bus_ready_i && wb_valid_i;
    assign rdsw_sel = !bus_ready_i && !wb_valid_i && rdsw_valid_i;

    always_comb begin
        bus_aux = '0;
        bus_aux.wb.byte_mask = '1; // fill covers the whole line
    end

    always_comb begin
        if (bus_sel) begin
            addr_o = bus_addr_i;
            data_o = bus_data_i;
            aux_o  = bus_aux;
        end else if (wb_sel) begin
            addr_o = wb_addr_i;
            data_o = wb_data_i;
            aux_o  = wb_aux_i;
        end else begin
            addr_o = rdsw_addr_i;
            data_o = '0; // no data for rd/sw
            aux_o  = rdsw_aux_i;
        end
    end

    assign valid_o    = bus_sel || wb_sel || rdsw_sel;
    assign aq_empty_o = !valid_o;

    assign from_bus_o = bus_sel;
    assign w_o        = wb_sel;
    assign sw_o       = rdsw_sel && rdsw_is_sw_i;
    assign r_o        = rdsw_sel && !rdsw_is_sw_i;

    // read goes to exactly one source
    assign bus_ack_o  = read_i && bus_sel;
    assign wb_pop_o   = read_i && wb_sel;
    assign rdsw_pop_o = read_i && rdsw_sel;

endmodule

// ==== cacheaq_top.sv ====
`timescale 1ns/100ps
`include "cacheaq_config.svh"

module cacheaq_top (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  rdsw_clr_i,
    input  logic                  wb_clr_i,
    input  logic                  rd_write_i,
    input  logic [`AQ_ADDR_W-1:0] rd_addr_i,
    input  cacheaq_pkg::aq_aux_u  rd_aux_i,
    input  logic                  sw_write_i,
    input  logic [`AQ_ADDR_W-1:0] sw_addr_i,
    input  cacheaq_pkg::aq_aux_u  sw_aux_i,
    input  logic                  wb_write_i,
    input  logic [`AQ_ADDR_W-1:0] wb_addr_i,
    input  logic [`AQ_DATA_W-1:0] wb_data_i,
    input  cacheaq_pkg::aq_aux_u  wb_aux_i,
    input  logic                  bus_ready_i,
    input  logic [`AQ_ADDR_W-1:0] bus_addr_i,
    input  logic [`AQ_DATA_W-1:0] bus_data_i,
    input  logic                  read_i,
    output logic                  valid_o,
    output logic [`AQ_ADDR_W-1:0] addr_o,
    output logic [`AQ_DATA_W-1:0] data_o,
    output cacheaq_pkg::aq_aux_u  aux_o,
    output logic                  from_bus_o,
    output logic                  w_o,
    output logic                  sw_o,
    output logic                  r_o,
    output logic                  bus_ack_o,
    output logic                  aq_empty_o,
    output logic                  rdaq_full_o,
    output logic                  swaq_full_o,
    output logic                  wbaq_full_o
);

    logic                  rdsw_valid;
    logic                  rdsw_is_sw;
    logic [`AQ_ADDR_W-1:0] rdsw_addr;
    cacheaq_pkg::aq_aux_u  rdsw_aux;
    logic                  rdsw_pop;
    logic                  wb_valid;
    logic [`AQ_ADDR_W-1:0] wb_addr;
    logic [`AQ_DATA_W-1:0] wb_data;
    cacheaq_pkg::aq_aux_u  wb_aux;
    logic                  wb_pop;

    rdsw_queues u_rdsw (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .clr_i      (rdsw_clr_i),
        .rd_write_i (rd_write_i),
        .rd_addr_i  (rd_addr_i),
        .rd_aux_i   (rd_aux_i),
        .sw_write_i (sw_write_i),
        .sw_addr_i  (sw_addr_i),
        .sw_aux_i   (sw_aux_i),
        .pop_i      (rdsw_pop),
        .valid_o    (rdsw_valid),
        .is_sw_o    (rdsw_is_sw),
        .addr_o     (rdsw_addr),
        .aux_o      (rdsw_aux),
        .rd_full_o  (rdaq_full_o),
        .sw_full_o  (swaq_full_o)
    );

    wb_queue u_wb (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .clr_i   (wb_clr_i),
        .write_i (wb_write_i),
        .addr_i  (wb_addr_i),
        .data_i  (wb_data_i),
        .aux_i   (wb_aux_i),
        .pop_i   (wb_pop),
        .valid_o (wb_valid),
        .addr_o  (wb_addr),
        .data_o  (wb_data),
        .aux_o   (wb_aux),
        .full_o  (wbaq_full_o)
    );

    aq_arbiter u_arb (
        .bus_ready_i  (bus_ready_i),
        .bus_addr_i   (bus_addr_i),
        .bus_data_i   (bus_data_i),
        .wb_valid_i   (wb_valid),
        .wb_addr_i    (wb_addr),
        .wb_data_i    (wb_data),
        .wb_aux_i     (wb_aux),
        .rdsw_valid_i (rdsw_valid),
        .rdsw_is_sw_i (rdsw_is_sw),
        .rdsw_addr_i  (rdsw_addr),
        .rdsw_aux_i   (rdsw_aux),
        .read_i       (read_i),
        .valid_o      (valid_o),
        .addr_o       (addr_o),
        .data_o       (data_o),
        .aux_o        (aux_o),
        .from_bus_o   (from_bus_o),
        .w_o          (w_o),
        .sw_o         (sw_o),
        .r_o          (r_o),
        .bus_ack_o    (bus_ack_o),
        .wb_pop_o     (wb_pop),
        .rdsw_pop_o   (rdsw_pop),
        .aq_empty_o   (aq_empty_o)
    );

endmodule

// ==== tb_cacheaq.sv ====
`timescale 1ns/100ps
`include "cacheaq_config.svh"

module tb_cacheaq;

    localparam int MAX_CYCLES = 2000;
    localparam logic [3:0] SRC_BUS = 4'b1000;
    localparam logic [3:0] SRC_WB  = 4'b0100;
    localparam logic [3:0] SRC_SW  = 4'b0010;
    localparam logic [3:0] SRC_RD  = 4'b0001;

    logic                  clk_i;
    logic                  rst_i;
    logic                  rdsw_clr_i;
    logic                  wb_clr_i;
    logic                  rd_write_i;
    logic [`AQ_ADDR_W-1:0] rd_addr_i;
    cacheaq_pkg::aq_aux_u  rd_aux_i;
    logic                  sw_write_i;
    logic [`AQ_ADDR_W-1:0] sw_addr_i;
    cacheaq_pkg::aq_aux_u  sw_aux_i;
    logic                  wb_write_i;
    logic [`AQ_ADDR_W-1:0] wb_addr_i;
    logic [`AQ_DATA_W-1:0] wb_data_i;
    cacheaq_pkg::aq_aux_u  wb_aux_i;
    logic                  bus_ready_i;
    logic [`AQ_ADDR_W-1:0] bus_addr_i;
    logic [`AQ_DATA_W-1:0] bus_data_i;
    logic                  read_i;
    logic                  valid_o;
    logic [`AQ_ADDR_W-1:0] addr_o;
    logic [`AQ_DATA_W-1:0] data_o;
    cacheaq_pkg::aq_aux_u  aux_o;
    logic                  from_bus_o;
    logic                  w_o;
    logic                  sw_o;
    logic                  r_o;
    logic                  bus_ack_o;
    logic                  aq_empty_o;
    logic                  rdaq_full_o;
    logic                  swaq_full_o;
    logic                  wbaq_full_o;

    int          errors = 0;
    int          checks = 0;
    int          tests  = 0;
    int          cycles = 0;
    logic [31:0] lfsr   = 32'h9546_2200;

    cacheaq_top UUT (.*);

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    // watchdog
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [`AQ_DATA_W-1:0] rand_bits(input int n);
        logic [`AQ_DATA_W-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1); // one step per bit
            v = {v[`AQ_DATA_W-2:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [`AQ_ADDR_W-1:0] rand_addr();
        logic [`AQ_DATA_W-1:0] v;
        v = rand_bits(`AQ_ADDR_W);
        return v[`AQ_ADDR_W-1:0];
    endfunction

    function automatic cacheaq_pkg::aq_aux_u rand_aux();
        logic [`AQ_DATA_W-1:0] v;
        v = rand_bits(`AQ_AUX_W);
        return v[`AQ_AUX_W-1:0];
    endfunction

    task automatic check_addr(input string name, input logic [`AQ_ADDR_W-1:0] exp, act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_data(input string name, input logic [`AQ_DATA_W-1:0] exp, act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_aux(input string name, input cacheaq_pkg::aq_aux_u exp, act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // flags as {from_bus, w, sw, r}
    task automatic check_src(input string name, input logic [3:0] exp, act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic push_rdsw(input logic is_sw, input logic [`AQ_ADDR_W-1:0] addr,
                             input cacheaq_pkg::aq_aux_u aux);
        @(posedge clk_i);
        if (is_sw) begin
            sw_write_i <= 1'b1;
            sw_addr_i  <= addr;
            sw_aux_i   <= aux;
        end else begin
            rd_write_i <= 1'b1;
            rd_addr_i  <= addr;
            rd_aux_i   <= aux;
        end
        @(posedge clk_i);
        rd_write_i <= 1'b0;
        sw_write_i <= 1'b0;
    endtask

    task automatic push_wb(input logic [`AQ_ADDR_W-1:0] addr, input logic [`AQ_DATA_W-1:0] data,
                           input cacheaq_pkg::aq_aux_u aux);
        @(posedge clk_i);
        wb_write_i <= 1'b1;
        wb_addr_i  <= addr;
        wb_data_i  <= data;
        wb_aux_i   <= aux;
        @(posedge clk_i);
        wb_write_i <= 1'b0;
    endtask

    task automatic pulse_clear(input logic rdsw, input logic wb);
        @(posedge clk_i);
        rdsw_clr_i <= rdsw;
        wb_clr_i   <= wb;
        @(posedge clk_i);
        rdsw_clr_i <= 1'b0;
        wb_clr_i   <= 1'b0;
    endtask

    // waits for an offer, checks it, then takes it with read_i
    task automatic pop_expect(input logic [3:0] src, input logic [`AQ_ADDR_W-1:0] addr,
                              input logic [`AQ_DATA_W-1:0] data,
                              input cacheaq_pkg::aq_aux_u aux, input logic ack);
        @(negedge clk_i);
        while (!valid_o) begin
            @(negedge clk_i);
        end
        check_src("source flags", src, {from_bus_o, w_o, sw_o, r_o});
        check_addr("addr_o", addr, addr_o);
        check_data("data_o", data, data_o);
        check_aux("aux_o", aux, aux_o);
        check_flag("bus_ack_o", 1'b0, bus_ack_o); // no read yet
        @(posedge clk_i);
        read_i <= 1'b1;
        @(negedge clk_i);
        check_flag("bus_ack_o", ack, bus_ack_o);
        @(posedge clk_i);
        read_i <= 1'b0;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - errs_before);
        end
    endtask

    task automatic test_reset_reads();
        int                    e0;
        logic [`AQ_ADDR_W-1:0] a [5];
        cacheaq_pkg::aq_aux_u  x [5];
        e0 = errors;
        @(negedge clk_i);
        check_flag("valid_o", 1'b0, valid_o);
        check_flag("aq_empty_o", 1'b1, aq_empty_o);
        check_src("source flags", 4'b0000, {from_bus_o, w_o, sw_o, r_o});
        check_flag("rdaq_full_o", 1'b0, rdaq_full_o);
        check_flag("swaq_full_o", 1'b0, swaq_full_o);
        check_flag("wbaq_full_o", 1'b0, wbaq_full_o);
        for (int i = 0; i < 5; i++) begin
            a[i] = rand_addr();
            x[i] = rand_aux();
            push_rdsw(1'b0, a[i], x[i]);
        end
        for (int i = 0; i < 5; i++) begin
            pop_expect(SRC_RD, a[i], '0, x[i], 1'b0);
        end
        @(negedge clk_i);
        check_flag("valid_o", 1'b0, valid_o);
        finish_test("reset and read order", e0);
    endtask

    task automatic test_priority();
        int                    e0;
        logic [`AQ_ADDR_W-1:0] a_rd, a_sw, a_wb, a_bus;
        logic [`AQ_DATA_W-1:0] d_wb, d_bus;
        cacheaq_pkg::aq_aux_u  x_rd, x_sw, x_wb, x_bus;
        e0 = errors;
        a_rd = rand_addr();
        x_rd = rand_aux();
        a_sw = rand_addr();
        x_sw = rand_aux();
        a_wb = rand_addr();
        x_wb = rand_aux();
        d_wb = rand_bits(`AQ_DATA_W);
        a_bus = rand_addr();
        d_bus = rand_bits(`AQ_DATA_W);
        x_bus = '0;
        x_bus.wb.byte_mask = '1; // fill covers all bytes
        push_rdsw(1'b0, a_rd, x_rd);
        push_rdsw(1'b1, a_sw, x_sw);
        push_wb(a_wb, d_wb, x_wb);
        @(posedge clk_i);
        bus_ready_i <= 1'b1;
        bus_addr_i  <= a_bus;
        bus_data_i  <= d_bus;
        pop_expect(SRC_BUS, a_bus, d_bus, x_bus, 1'b1);
        bus_ready_i <= 1'b0;
        pop_expect(SRC_WB, a_wb, d_wb, x_wb, 1'b0);
        pop_expect(SRC_SW, a_sw, '0, x_sw, 1'b0);
        pop_expect(SRC_RD, a_rd, '0, x_rd, 1'b0);
        @(negedge clk_i);
        check_flag("aq_empty_o", 1'b1, aq_empty_o);
        finish_test("source priority", e0);
    endtask

    task automatic test_sw_full();
        int                    e0;
        logic [`AQ_ADDR_W-1:0] a [9];
        cacheaq_pkg::aq_aux_u  x [9];
        e0 = errors;
        for (int i = 0; i < 9; i++) begin
            a[i] = rand_addr();
            x[i] = rand_aux();
            push_rdsw(1'b1, a[i], x[i]);
            @(negedge clk_i);
            check_flag("swaq_full_o", (i >= 7), swaq_full_o);
        end
        for (int i = 0; i < 8; i++) begin
            pop_expect(SRC_SW, a[i], '0, x[i], 1'b0);
        end
        @(negedge clk_i);
        check_flag("valid_o", 1'b0, valid_o); // ninth push was dropped
        finish_test("store-write full", e0);
    endtask

    task automatic test_wb_merge();
        int                    e0;
        logic [`AQ_ADDR_W-1:0] a1, a2;
        logic [`AQ_DATA_W-1:0] d1, d2, d3, d_exp;
        cacheaq_pkg::aq_aux_u  x1, x2, x3, x_exp;
        e0 = errors;
        a1 = rand_addr();
        a2 = a1 ^ 1'b1;
        d1 = rand_bits(`AQ_DATA_W);
        d2 = rand_bits(`AQ_DATA_W);
        d3 = rand_bits(`AQ_DATA_W);
        x1 = rand_aux();
        x2 = rand_aux();
        x3 = rand_aux();
        if (x2.wb.byte_mask == x1.wb.byte_mask) begin
            x2.wb.byte_mask = ~x1.wb.byte_mask;
        end
        d_exp = d1;
        for (int b = 0; b < `AQ_MASK_W; b++) begin
            if (x2.wb.byte_mask[b]) begin
                d_exp[b*8 +: 8] = d2[b*8 +: 8];
            end
        end
        x_exp = x2;
        x_exp.wb.byte_mask = x1.wb.byte_mask | x2.wb.byte_mask;
        push_wb(a1, d1, x1);
        push_wb(a1, d2, x2);
        push_wb(a2, d3, x3);
        pop_expect(SRC_WB, a1, d_exp, x_exp, 1'b0);
        pop_expect(SRC_WB, a2, d3, x3, 1'b0);
        @(negedge clk_i);
        check_flag("valid_o", 1'b0, valid_o);
        finish_test("writeback merge", e0);
    endtask

    task automatic test_clears();
        int                    e0;
        logic [`AQ_ADDR_W-1:0] a1, a2;
        logic [`AQ_DATA_W-1:0] d1, d2;
        cacheaq_pkg::aq_aux_u  x1, x2;
        e0 = errors;
        a1 = rand_addr();
        a2 = a1 ^ 1'b1;
        d1 = rand_bits(`AQ_DATA_W);
        d2 = rand_bits(`AQ_DATA_W);
        x1 = rand_aux();
        x2 = rand_aux();
        push_rdsw(1'b0, rand_addr(), rand_aux());
        push_rdsw(1'b1, rand_addr(), rand_aux());
        push_wb(a1, d1, x1);
        pulse_clear(1'b1, 1'b0);
        pop_expect(SRC_WB, a1, d1, x1, 1'b0);
        @(negedge clk_i);
        check_flag("valid_o", 1'b0, valid_o); // rd and sw are gone
        push_wb(a2, d2, x2);
        @(negedge clk_i);
        check_src("source flags", SRC_WB, {from_bus_o, w_o, sw_o, r_o});
        check_addr("addr_o", a2, addr_o);
        pulse_clear(1'b0, 1'b1);
        @(negedge clk_i);
        check_flag("aq_empty_o", 1'b1, aq_empty_o);
        check_flag("valid_o", 1'b0, valid_o);
        finish_test("queue clears", e0);
    endtask

    initial begin
        rst_i       = 1'b1;
        rdsw_clr_i  = 1'b0;
        wb_clr_i    = 1'b0;
        rd_write_i  = 1'b0;
        rd_addr_i   = '0;
        rd_aux_i    = '0;
        sw_write_i  = 1'b0;
        sw_addr_i   = '0;
        sw_aux_i    = '0;
        wb_write_i  = 1'b0;
        wb_addr_i   = '0;
        wb_data_i   = '0;
        wb_aux_i    = '0;
        bus_ready_i = 1'b0;
        bus_addr_i  = '0;
        bus_data_i  = '0;
        read_i      = 1'b0;
        repeat (10) @(posedge clk_i);
        rst_i <= 1'b0;
        test_reset_reads();
        test_priority();
        test_sw_full();
        test_wb_merge();
        test_clears();
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
cacheaq_pkg.sv
aq_fifo.sv
rdsw_queues.sv
wb_queue.sv
aq_arbiter.sv
cacheaq_top.sv
tb_cacheaq.sv
